// File: fm_top.f
hdl/fm_pkg.sv
hdl/fm_clk_en.sv
hdl/fm_regs.sv
hdl/fm_timer.sv
hdl/fm_dac_out.sv
hdl/fm_top.sv
sim/fm_top_tb.sv

// File: hdl/fm_clk_en.sv
// Assumes CLK_DIV and SLOTS are at least 1 and that cen is a clock enable on clk
`timescale 1ns/100ps

module fm_clk_en #(
    parameter int CLK_DIV = 6,
    parameter int SLOTS   = 24
) (
    input  logic clk,
    input  logic rst_n,
    input  logic cen,
    output logic clk_en,
    output logic sample
);
    localparam int DIV_W  = $clog2(CLK_DIV + 1);
    localparam int SLOT_W = $clog2(SLOTS + 1);

    logic [DIV_W-1:0]  div_cnt;
    logic [SLOT_W-1:0] slot_cnt;
    logic              last_slot;

    assign clk_en    = cen && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign last_slot = (slot_cnt == SLOT_W'(SLOTS - 1));
    assign sample    = clk_en && last_slot; // Stands in for the zero slot

    // Counts cen ticks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (cen) begin
            div_cnt <= clk_en ? '0 : div_cnt + DIV_W'(1);
        end
    end

    // Slot position within one sample
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_cnt <= '0;
        end else if (clk_en) begin
            slot_cnt <= last_slot ? '0 : slot_cnt + SLOT_W'(1);
        end
    end

endmodule

// File: hdl/fm_dac_out.sv
// Outputs carry the channel 6 DAC only and update once per sample strobe
`timescale 1ns/100ps

module fm_dac_out (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                sample,
    input  fm_pkg::dac_cfg_t                    cfg,
    output logic signed [fm_pkg::SAMPLE_W-1:0]  snd_left,
    output logic signed [fm_pkg::SAMPLE_W-1:0]  snd_right,
    output logic                                snd_sample
);
    logic signed [7:0]                 dac_s;
    logic signed [fm_pkg::SAMPLE_W-1:0] dac_ext;
    logic signed [fm_pkg::SAMPLE_W-1:0] dac_val;

    // Offset binary to two's complement
    assign dac_s   = $signed({~cfg.data[7], cfg.data[6:0]});
    assign dac_ext = $signed({{(fm_pkg::SAMPLE_W - 8){dac_s[7]}}, dac_s});
    assign dac_val = dac_ext <<< fm_pkg::DAC_SHIFT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= sample;  // Marks the update
            if (sample) begin
                if (cfg.en) begin
                    snd_left  <= cfg.pan_l ? dac_val : '0;
                    snd_right <= cfg.pan_r ? dac_val : '0;
                end else begin
                    // Disabled DAC is silent on both sides
                    snd_left  <= '0;
                    snd_right <= '0;
                end
            end
        end
    end

endmodule

// File: hdl/fm_pkg.sv
// Only bank 0 timer, DAC and channel 6 pan registers are mapped and FM voice registers have no entry
package fm_pkg;

    // Timer value widths
    localparam int TIMER_A_W = 10;
    localparam int TIMER_B_W = 8;

    // Bank 0 register addresses
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;  // Value A bits 9..2
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;  // Value A bits 1..0
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL  = 8'h27;
    localparam logic [7:0] REG_DAC_DATA   = 8'h2A;
    localparam logic [7:0] REG_DAC_EN     = 8'h2B;
    localparam logic [7:0] REG_PAN_CH6    = 8'hB6;

    // Bit positions in the timer control register
    localparam int CTL_RUN_A = 0;
    localparam int CTL_RUN_B = 1;
    localparam int CTL_IRQ_A = 2;
    localparam int CTL_IRQ_B = 3;
    localparam int CTL_CLR_A = 4;   // Pulse, not stored
    localparam int CTL_CLR_B = 5;   // Pulse, not stored

    // DAC enable and pan bits
    localparam int DAC_EN_BIT = 7;
    localparam int PAN_L_BIT  = 7;
    localparam int PAN_R_BIT  = 6;

    // Sound output format
    localparam int SAMPLE_W  = 16;
    localparam int DAC_SHIFT = 6;

    // Register block to one timer
    typedef struct packed {
        logic run;      // Counts while set
        logic irq_en;   // Overflow may set the flag
        logic clr_flag; // One clock wide
    } timer_ctl_t;

    // Register block to DAC output
    typedef struct packed {
        logic [7:0] data;   // Offset binary
        logic       en;
        logic       pan_l;
        logic       pan_r;
    } dac_cfg_t;

endpackage

// File: hdl/fm_regs.sv
// Bank 1 writes (addr[1] set) are dropped and unmapped registers accept writes without effect
`timescale 1ns/100ps

module fm_regs #(
    parameter int BUSY_TICKS = 32
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clk_en,
    input  logic [7:0]                    din,
    input  logic [1:0]                    addr,
    input  logic                          cs_n,
    input  logic                          wr_n,
    input  logic                          flag_a,
    input  logic                          flag_b,
    output logic [7:0]                    dout,
    output fm_pkg::timer_ctl_t            tmr_a_ctl,
    output fm_pkg::timer_ctl_t            tmr_b_ctl,
    output logic [fm_pkg::TIMER_A_W-1:0]  tmr_a_value,
    output logic [fm_pkg::TIMER_B_W-1:0]  tmr_b_value,
    output fm_pkg::dac_cfg_t              dac_cfg
);
    localparam int BUSY_W = $clog2(BUSY_TICKS + 1);

    logic              write;
    logic              addr_wr;
    logic              data_wr;
    logic [7:0]        reg_addr;
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;

    assign write   = !cs_n && !wr_n;
    assign addr_wr = write && !addr[1] && !addr[0];
    assign data_wr = write && !addr[1] && addr[0];

    // Address latch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_addr <= '0;
        end else if (addr_wr) begin
            reg_addr <= din;
        end
    end

    // Busy runs on the internal enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(BUSY_TICKS);  // A write during busy restarts it
        end else if (clk_en && busy_cnt != '0) begin
            busy_cnt <= busy_cnt - BUSY_W'(1);
        end
    end

    assign busy = (busy_cnt != '0);

    // Status byte, same for every address
    assign dout = {busy, 5'd0, flag_b, flag_a};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tmr_a_ctl   <= '0;
            tmr_b_ctl   <= '0;
            tmr_a_value <= '0;
            tmr_b_value <= '0;
            dac_cfg     <= '{data: 8'd0, en: 1'b0, pan_l: 1'b1, pan_r: 1'b1};
        end else begin
            // Flag clears last one clock
            tmr_a_ctl.clr_flag <= 1'b0;
            tmr_b_ctl.clr_flag <= 1'b0;
            if (data_wr) begin
                case (reg_addr)
                    fm_pkg::REG_TIMER_A_HI: begin
                        tmr_a_value[fm_pkg::TIMER_A_W-1:2] <= din;
                    end
                    fm_pkg::REG_TIMER_A_LO: begin
                        tmr_a_value[1:0] <= din[1:0];
                    end
                    fm_pkg::REG_TIMER_B: begin
                        tmr_b_value <= din;
                    end
                    fm_pkg::REG_TIMER_CTL: begin
                        tmr_a_ctl.run      <= din[fm_pkg::CTL_RUN_A];
                        tmr_b_ctl.run      <= din[fm_pkg::CTL_RUN_B];
                        tmr_a_ctl.irq_en   <= din[fm_pkg::CTL_IRQ_A];
                        tmr_b_ctl.irq_en   <= din[fm_pkg::CTL_IRQ_B];
                        tmr_a_ctl.clr_flag <= din[fm_pkg::CTL_CLR_A];
                        tmr_b_ctl.clr_flag <= din[fm_pkg::CTL_CLR_B];
                    end
                    fm_pkg::REG_DAC_DATA: begin
                        dac_cfg.data <= din;
                    end
                    fm_pkg::REG_DAC_EN: begin
                        dac_cfg.en <= din[fm_pkg::DAC_EN_BIT];
                    end
                    fm_pkg::REG_PAN_CH6: begin
                        dac_cfg.pan_l <= din[fm_pkg::PAN_L_BIT];
                        dac_cfg.pan_r <= din[fm_pkg::PAN_R_BIT];
                    end
                    default: begin
                        // FM voice registers land here
                    end
                endcase
            end
        end
    end

endmodule

// File: hdl/fm_timer.sv
// Ticks only on sample strobes divided by PRESCALE, and cnt_t must be a packed unsigned vector
`timescale 1ns/100ps

module fm_timer #(
    parameter type cnt_t    = logic [7:0],
    parameter int  PRESCALE = 1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample,
    input  fm_pkg::timer_ctl_t ctl,
    input  cnt_t               value,
    output logic               flag
);
    localparam int PRE_W = $clog2(PRESCALE + 1);

    logic [PRE_W-1:0] pre_cnt;
    logic             run_d;
    logic             tick;
    logic             load;
    logic             ovf;
    cnt_t             cnt;

    assign tick = sample && (pre_cnt == PRE_W'(PRESCALE - 1));
    assign load = ctl.run && !run_d;               // Rising edge of run
    assign ovf  = ctl.run && !load && tick && (&cnt);

    // Prescaler restarts whenever the timer stops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_cnt <= '0;
        end else if (!ctl.run) begin
            pre_cnt <= '0;
        end else if (sample) begin
            pre_cnt <= tick ? '0 : pre_cnt + PRE_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_d <= 1'b0;
            cnt   <= '0;
        end else begin
            run_d <= ctl.run;
            if (load || ovf) begin
                cnt <= value;
            end else if (ctl.run && tick) begin
                cnt <= cnt + cnt_t'(1);
            end
        end
    end

    // Clear beats a simultaneous overflow
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag <= 1'b0;
        end else if (ctl.clr_flag) begin
            flag <= 1'b0;
        end else if (ovf && ctl.irq_en) begin
            flag <= 1'b1;
        end
    end

endmodule

// File: hdl/fm_top.sv
// Timers and DAC only with no FM synthesis, and the sound outputs hold just the DAC sample
`timescale 1ns/100ps

module fm_top #(
    parameter int CLK_DIV    = 6,
    parameter int SLOTS      = 24,
    parameter int BUSY_TICKS = 32
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               cen,     // Tie high if not needed
    input  logic [7:0]                         din,
    input  logic [1:0]                         addr,
    input  logic                               cs_n,
    input  logic                               wr_n,
    output logic [7:0]                         dout,
    output logic                               irq_n,
    output logic signed [fm_pkg::SAMPLE_W-1:0] snd_left,
    output logic signed [fm_pkg::SAMPLE_W-1:0] snd_right,
    output logic                               snd_sample
);
    localparam int TMR_A_PRESCALE = 1;
    localparam int TMR_B_PRESCALE = 16;  // Timer B runs 16 times slower

    logic                         clk_en;
    logic                         sample;
    logic                         flag_a;
    logic                         flag_b;
    fm_pkg::timer_ctl_t           tmr_a_ctl;
    fm_pkg::timer_ctl_t           tmr_b_ctl;
    logic [fm_pkg::TIMER_A_W-1:0] tmr_a_value;
    logic [fm_pkg::TIMER_B_W-1:0] tmr_b_value;
    fm_pkg::dac_cfg_t             dac_cfg;

    fm_clk_en #(.CLK_DIV(CLK_DIV), .SLOTS(SLOTS)) u_clk_en (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .cen    ( cen    ),
        .clk_en ( clk_en ),
        .sample ( sample )
    );

    fm_regs #(.BUSY_TICKS(BUSY_TICKS)) u_regs (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .clk_en      ( clk_en      ),
        .din         ( din         ),
        .addr        ( addr        ),
        .cs_n        ( cs_n        ),
        .wr_n        ( wr_n        ),
        .flag_a      ( flag_a      ),
        .flag_b      ( flag_b      ),
        .dout        ( dout        ),
        .tmr_a_ctl   ( tmr_a_ctl   ),
        .tmr_b_ctl   ( tmr_b_ctl   ),
        .tmr_a_value ( tmr_a_value ),
        .tmr_b_value ( tmr_b_value ),
        .dac_cfg     ( dac_cfg     )
    );

    fm_timer #(
        .cnt_t    ( logic [fm_pkg::TIMER_A_W-1:0] ),
        .PRESCALE ( TMR_A_PRESCALE )
    ) u_timer_a (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .sample ( sample      ),
        .ctl    ( tmr_a_ctl   ),
        .value  ( tmr_a_value ),
        .flag   ( flag_a      )
    );

    fm_timer #(
        .cnt_t    ( logic [fm_pkg::TIMER_B_W-1:0] ),
        .PRESCALE ( TMR_B_PRESCALE )
    ) u_timer_b (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .sample ( sample      ),
        .ctl    ( tmr_b_ctl   ),
        .value  ( tmr_b_value ),
        .flag   ( flag_b      )
    );

    fm_dac_out u_dac (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .sample     ( sample     ),
        .cfg        ( dac_cfg    ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    assign irq_n = !(flag_a || flag_b);  // Low while either flag is set

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds fm_top_tb with Verilator and runs it, the log decides pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f fm_top.f --top-module fm_top_tb \
    -Mdir obj_dir -o fm_top_sim > build.log 2>&1 &&
./obj_dir/fm_top_sim > sim.log 2>&1 ||
{ echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Finished with errors" sim.log &&
{ echo "Simulation FAILED, see sim.log"; exit 1; } ||
{ echo "Simulation passed"; exit 0; }

// File: sim/fm_top_tb.sv
// Default parameters with cen held high, so one sample period is 144 clocks of 10 ns
`timescale 1ns/100ps

module fm_top_tb;
    localparam int CLK_DIV     = 6;
    localparam int SLOTS       = 24;
    localparam int BUSY_TICKS  = 32;
    localparam int SAMPLE_CLKS = CLK_DIV * SLOTS;
    localparam int FIXED_ROWS  = 8;
    localparam int NUM_ROWS    = FIXED_ROWS + 4;
    // Reset, busy, timer A, both timer B runs, then three samples per DAC row
    localparam int RUN_SAMPLES = 4 + 2 + 8 + 40 + 50 + 3 * NUM_ROWS;
    localparam int WATCHDOG_NS = (RUN_SAMPLES + 20) * SAMPLE_CLKS * 10;

    typedef struct packed {
        logic [7:0]         data;
        logic               en;
        logic               pan_l;
        logic               pan_r;
        logic signed [15:0] exp_l;
        logic signed [15:0] exp_r;
    } dac_row_t;

    logic               clk;
    logic               rst_n;
    logic               cen;
    logic [7:0]         din;
    logic [1:0]         addr;
    logic               cs_n;
    logic               wr_n;
    logic [7:0]         dout;
    logic               irq_n;
    logic signed [15:0] snd_left;
    logic signed [15:0] snd_right;
    logic               snd_sample;

    dac_row_t dac_table [NUM_ROWS];
    int       mismatches;
    int       failures;
    integer   seed;

    fm_top u_fm_top (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen        ( cen        ),
        .din        ( din        ),
        .addr       ( addr       ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Offset binary byte shifted by 6 on a panned, enabled side
    function automatic logic signed [15:0] dac_level(input logic [7:0] data, input logic en,
                                                     input logic pan);
        int level;
        level = (int'(data) - 128) * 64;
        if (en && pan) begin
            return level[15:0];
        end
        return '0;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        mismatches++;
        $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    endtask

    // Address cycle then data cycle
    task automatic reg_write(input logic [7:0] reg_addr, input logic [7:0] value);
        @(negedge clk);
        addr = 2'd0;
        din  = reg_addr;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(negedge clk);
        addr = 2'd1;
        din  = value;
        @(negedge clk);
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic wait_status_bit(input logic [2:0] bit_idx, input logic level,
                                   input int max_clocks, output bit seen, output int clocks);
        clocks = 0;
        seen   = 1'b0;
        while (!seen && clocks < max_clocks) begin
            @(negedge clk);
            clocks++;
            seen = (dout[bit_idx] === level);
        end
        if (!seen) begin
            failures++;
            $display("Status bit %0d never reached %0b within %0d clocks", bit_idx, level,
                     max_clocks);
        end
    endtask

    task automatic wait_sample_pulse(output bit seen, output int clocks);
        clocks = 0;
        seen   = 1'b0;
        while (!seen && clocks < 2 * SAMPLE_CLKS) begin
            @(negedge clk);
            clocks++;
            seen = (snd_sample === 1'b1);
        end
        if (!seen) begin
            failures++;
            $display("No snd_sample pulse within %0d clocks", 2 * SAMPLE_CLKS);
        end
    endtask

    initial begin
        bit     seen;
        bit     stray;
        int     clocks;
        int     i;
        integer r;
        rst_n      = 1'b0;
        cen        = 1'b1;
        din        = 8'd0;
        addr       = 2'd0;
        cs_n       = 1'b1;
        wr_n       = 1'b1;
        mismatches = 0;
        failures   = 0;
        seed       = 85;
        dac_table[0] = '{8'h80, 1'b1, 1'b1, 1'b1, 16'h0000, 16'h0000};
        dac_table[1] = '{8'hFF, 1'b1, 1'b1, 1'b1, 16'h1FC0, 16'h1FC0};
        dac_table[2] = '{8'h00, 1'b1, 1'b1, 1'b1, 16'hE000, 16'hE000};
        dac_table[3] = '{8'h40, 1'b1, 1'b1, 1'b0, 16'hF000, 16'h0000};
        dac_table[4] = '{8'hC0, 1'b1, 1'b0, 1'b1, 16'h0000, 16'h1000};
        dac_table[5] = '{8'h90, 1'b0, 1'b1, 1'b1, 16'h0000, 16'h0000};  // DAC off
        dac_table[6] = '{8'h7F, 1'b1, 1'b1, 1'b1, 16'hFFC0, 16'hFFC0};
        dac_table[7] = '{8'h01, 1'b1, 1'b1, 1'b0, 16'hE040, 16'h0000};
        for (i = FIXED_ROWS; i < NUM_ROWS; i++) begin
            r = $random(seed);
            dac_table[i].data  = r[7:0];
            dac_table[i].en    = r[10] | r[11];  // Mostly enabled
            dac_table[i].pan_l = r[8];
            dac_table[i].pan_r = r[9];
            dac_table[i].exp_l = dac_level(r[7:0], dac_table[i].en, r[8]);
            dac_table[i].exp_r = dac_level(r[7:0], dac_table[i].en, r[9]);
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // Idle state and steady sample rate
        if (dout !== 8'h00) report_mismatch("dout", 16'(dout), 16'h0000);
        if (irq_n !== 1'b1) report_mismatch("irq_n", 16'(irq_n), 16'h0001);
        wait_sample_pulse(seen, clocks);
        repeat (3) begin
            wait_sample_pulse(seen, clocks);
            if (seen && clocks != SAMPLE_CLKS) begin
                failures++;
                $display("Sample period was %0d clocks instead of %0d", clocks, SAMPLE_CLKS);
            end
            if (snd_left !== 16'h0000) report_mismatch("snd_left", snd_left, 16'h0000);
            if (snd_right !== 16'h0000) report_mismatch("snd_right", snd_right, 16'h0000);
        end

        // Busy after a data write
        reg_write(8'h2B, 8'h00);
        if (dout[7] !== 1'b1) report_mismatch("busy", 16'(dout[7]), 16'h0001);
        wait_status_bit(3'd7, 1'b0, BUSY_TICKS * CLK_DIV + 8, seen, clocks);
        stray = 1'b0;
        repeat (50) begin
            @(negedge clk);
            if (dout[7] !== 1'b0 && !stray) begin
                report_mismatch("busy", 16'(dout[7]), 16'h0000);
                stray = 1'b1;
            end
        end

        // Timer A with value 1020 overflows on the fourth tick
        reg_write(8'h24, 8'hFF);
        reg_write(8'h25, 8'h00);
        reg_write(8'h27, 8'h05);
        wait_status_bit(3'd0, 1'b1, 5 * SAMPLE_CLKS + 4, seen, clocks);
        if (seen && clocks < 3 * SAMPLE_CLKS) begin
            failures++;
            $display("flag_a set after only %0d clocks", clocks);
        end
        if (irq_n !== 1'b0) report_mismatch("irq_n", 16'(irq_n), 16'h0000);
        reg_write(8'h27, 8'h15);
        wait_status_bit(3'd0, 1'b0, 8, seen, clocks);
        if (irq_n !== 1'b1) report_mismatch("irq_n", 16'(irq_n), 16'h0001);
        reg_write(8'h27, 8'h10);  // Stop A

        // Timer B running with its interrupt masked
        reg_write(8'h26, 8'hFE);
        reg_write(8'h27, 8'h02);
        stray = 1'b0;
        repeat (40 * SAMPLE_CLKS) begin
            @(negedge clk);
            if (dout[1] !== 1'b0 && !stray) begin
                report_mismatch("flag_b", 16'(dout[1]), 16'h0000);
                stray = 1'b1;
            end
            if (irq_n !== 1'b1 && !stray) begin
                report_mismatch("irq_n", 16'(irq_n), 16'h0001);
                stray = 1'b1;
            end
        end
        reg_write(8'h27, 8'h00);
        reg_write(8'h27, 8'h0A);
        wait_status_bit(3'd1, 1'b1, 48 * SAMPLE_CLKS, seen, clocks);
        if (seen && clocks < 16 * SAMPLE_CLKS) begin
            failures++;
            $display("flag_b set after only %0d clocks", clocks);
        end
        if (irq_n !== 1'b0) report_mismatch("irq_n", 16'(irq_n), 16'h0000);
        reg_write(8'h27, 8'h20);
        wait_status_bit(3'd1, 1'b0, 8, seen, clocks);
        if (irq_n !== 1'b1) report_mismatch("irq_n", 16'(irq_n), 16'h0001);

        // DAC rows, checked on the second pulse after the writes
        for (i = 0; i < NUM_ROWS; i++) begin
            reg_write(8'h2A, dac_table[i].data);
            reg_write(8'h2B, {dac_table[i].en, 7'd0});
            reg_write(8'hB6, {dac_table[i].pan_l, dac_table[i].pan_r, 6'd0});
            wait_sample_pulse(seen, clocks);
            wait_sample_pulse(seen, clocks);
            if (seen && snd_left !== dac_table[i].exp_l) begin
                report_mismatch("snd_left", snd_left, dac_table[i].exp_l);
            end
            if (seen && snd_right !== dac_table[i].exp_r) begin
                report_mismatch("snd_right", snd_right, dac_table[i].exp_r);
            end
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        failures++;
        $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("Finished with errors");
        $finish;
    end

endmodule
